// File: fetch_cfg_pkg.sv
/*
 * Shared constants and base types of the instruction fetch stage.
 * Imported by every fetch module that needs widths, the reset NOP
 * or the default sizes handed down from the top level.
 */

`default_nettype none

package fetch_cfg_pkg;

    // data and address width
    localparam int unsigned XLEN = 32;

    // fetch address step, one 32-bit word
    localparam int unsigned WORD_BYTES = 4;

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [XLEN-1:0] insn_t;

    // addi x0,x0,0
    localparam insn_t NOP_INSN = 32'h0000_0013;

    // reset address of the fetch stage
    localparam addr_t DEFAULT_START_ADDRESS = '0;

    // instruction buffer sizing
    localparam int unsigned DEFAULT_BUFFER_DEPTH = 4;
    localparam int unsigned DEFAULT_ALMOST_FULL  = 1;

endpackage

`default_nettype wire

// File: fetch_types_pkg.sv
/*
 * Packed structs that travel between the fetch stage and its neighbours.
 * redirect_t bundles jump and context switch requests, issue_t bundles
 * what is handed to decode.
 */

`default_nettype none

package fetch_types_pkg;

    import fetch_cfg_pkg::*;

    //////////////////////////////////////////////////////////////////////////
    // redirect requests from execute / privileged logic
    //////////////////////////////////////////////////////////////////////////

    // strobes are single cycle pulses
    // context switch target wins over jump target
    typedef struct packed {
        logic  jump;
        logic  ctx_switch;
        addr_t jump_target;
        addr_t ctx_target;
    } redirect_t;

    //////////////////////////////////////////////////////////////////////////
    // issued instruction toward decode
    //////////////////////////////////////////////////////////////////////////

    // jumping marks the slot as squashed by a pending redirect
    // pc is the address of insn
    typedef struct packed {
        logic  valid;
        logic  jumping;
        insn_t insn;
        addr_t pc;
    } issue_t;

endpackage

`default_nettype wire

// File: fetch_ring_buffer.sv
/*
 * Circular FIFO of fetched instruction words.
 * Absorbs memory responses while decode stalls, flushes on a soft reset
 * or a redirect and flags when only a few free slots remain.
 */

`timescale 1ns/100ps
`default_nettype none

module fetch_ring_buffer #(
    parameter int unsigned DATA_WIDTH            = fetch_cfg_pkg::XLEN,
    parameter int unsigned BUFFER_DEPTH          = fetch_cfg_pkg::DEFAULT_BUFFER_DEPTH,
    parameter int unsigned ALMOST_FULL_THRESHOLD = fetch_cfg_pkg::DEFAULT_ALMOST_FULL
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  sys_reset_i,
    input  logic                  redirect_taken_i,
    input  logic                  push_i,
    input  logic                  pop_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    output logic                  push_done_o,
    output logic                  buf_valid_o,
    output logic                  almost_full_o,
    output logic [DATA_WIDTH-1:0] data_o
);

    localparam int unsigned PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(BUFFER_DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [BUFFER_DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] free_slots;

    logic flush;
    logic empty;
    logic full;
    logic pop_fire;

    // wrap at depth, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(BUFFER_DEPTH - 1))
            nxt = '0;
        else
            nxt = ptr + 1'b1;
        return nxt;
    endfunction

    //////////////////////////////////////////////////////////////////////////
    // status
    //////////////////////////////////////////////////////////////////////////

    // old words are stale after a redirect
    assign flush = sys_reset_i || redirect_taken_i;

    assign empty    = (count_q == '0);
    assign full     = (count_q == CNT_W'(BUFFER_DEPTH));
    assign pop_fire = pop_i && !empty;

    // a slot freed by a pop in the same cycle can take the push
    assign push_done_o = push_i && (!full || pop_fire);

    assign free_slots    = CNT_W'(BUFFER_DEPTH) - count_q;
    assign almost_full_o = (free_slots <= CNT_W'(ALMOST_FULL_THRESHOLD));

    assign buf_valid_o = !empty;
    assign data_o      = mem[rd_ptr_q];

    //////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush) begin
            // push and pop of this cycle are dropped too
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_done_o)
                wr_ptr_q <= ptr_next(wr_ptr_q);
            if (pop_fire)
                rd_ptr_q <= ptr_next(rd_ptr_q);
            case ({push_done_o, pop_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push_done_o)
            mem[wr_ptr_q] <= data_i;
    end

endmodule

`default_nettype wire

// File: fetch_addr_gen.sv
/*
 * Fetch address register of the instruction fetch stage.
 * Steps one word per cycle, jumps on a redirect and holds while memory
 * is busy or while the instruction buffer is nearly full under a stall.
 */

`timescale 1ns/100ps
`default_nettype none

module fetch_addr_gen #(
    parameter fetch_cfg_pkg::addr_t START_ADDRESS = fetch_cfg_pkg::DEFAULT_START_ADDRESS
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       sys_reset_i,
    input  logic                       busy_i,
    input  logic                       enable_i,
    input  logic                       almost_full_i,
    input  logic                       push_done_i,
    input  fetch_types_pkg::redirect_t redirect_i,
    output logic                       redirect_taken_o,
    output fetch_cfg_pkg::addr_t       instruction_address_o
);

    import fetch_cfg_pkg::*;

    addr_t target;
    addr_t addr_q;

    logic stall_hold;
    logic hold;
    logic hold_q;
    logic advance;

    //////////////////////////////////////////////////////////////////////////
    // redirect selection
    //////////////////////////////////////////////////////////////////////////

    // pulse, also flushes the buffer
    assign redirect_taken_o = redirect_i.jump || redirect_i.ctx_switch;

    // context switch has priority
    always_comb begin
        if (redirect_i.ctx_switch)
            target = redirect_i.ctx_target;
        else
            target = redirect_i.jump_target;
    end

    //////////////////////////////////////////////////////////////////////////
    // hold logic
    //////////////////////////////////////////////////////////////////////////

    // no room for another word while decode is stalled
    assign stall_hold = almost_full_i && !enable_i;

    // busy memory ignores the address anyway
    assign hold = busy_i || stall_hold;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            hold_q <= 1'b0;
        else if (sys_reset_i)
            hold_q <= 1'b0;
        else
            hold_q <= hold;
    end

    // held last cycle and the word just got into the buffer
    assign advance = !hold || (hold_q && push_done_i && !busy_i);

    //////////////////////////////////////////////////////////////////////////
    // address register
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            addr_q <= START_ADDRESS;
        end else if (sys_reset_i) begin
            addr_q <= START_ADDRESS;
        end else if (redirect_taken_o) begin
            // target visible one cycle after the strobe
            addr_q <= target;
        end else if (advance) begin
            addr_q <= addr_q + addr_t'(WORD_BYTES);
        end
    end

    // word aligned fetch only
    assign instruction_address_o = {addr_q[XLEN-1:2], 2'b00};

endmodule

`default_nettype wire

// File: fetch_issue.sv
/*
 * Issue registers of the fetch stage toward decode.
 * Decides which arriving memory words are live, requests buffer pushes,
 * picks buffered over live words and tracks the pc of the issued word.
 */

`timescale 1ns/100ps
`default_nettype none

module fetch_issue #(
    parameter fetch_cfg_pkg::addr_t START_ADDRESS = fetch_cfg_pkg::DEFAULT_START_ADDRESS
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    sys_reset_i,
    input  logic                    busy_i,
    input  logic                    enable_i,
    input  logic                    redirect_taken_i,
    input  logic                    buf_valid_i,
    input  fetch_cfg_pkg::insn_t    buf_data_i,
    input  fetch_cfg_pkg::insn_t    instruction_data_i,
    input  fetch_cfg_pkg::addr_t    instruction_address_i,
    output logic                    push_o,
    output fetch_types_pkg::issue_t issue_o
);

    import fetch_cfg_pkg::*;

    logic  busy_q;
    logic  redirect_q;
    addr_t prev_addr_q;
    logic  live;
    logic  valid_next;
    insn_t next_insn;

    logic  valid_q;
    logic  jumping_q;
    insn_t insn_q;
    addr_t pc_q;
    addr_t pc_jump_q;

    //////////////////////////////////////////////////////////////////////////
    // memory side
    //////////////////////////////////////////////////////////////////////////

    // what happened to the address of last cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q     <= 1'b1;
            redirect_q <= 1'b0;
        end else if (sys_reset_i) begin
            busy_q     <= 1'b1;
            redirect_q <= 1'b0;
        end else begin
            busy_q     <= busy_i;
            redirect_q <= redirect_taken_i;
        end
    end

    always_ff @(posedge clk) begin
        prev_addr_q <= instruction_address_i;
    end

    // word is live only if its address was accepted and then advanced
    // a held address is fetched again, so its first copy is dropped
    assign live = !busy_q && !redirect_q && (instruction_address_i != prev_addr_q);

    // straight through when decode takes it and nothing is queued
    assign push_o = live && !(enable_i && !buf_valid_i);

    // oldest word first
    assign valid_next = buf_valid_i || live;
    assign next_insn  = buf_valid_i ? buf_data_i : instruction_data_i;

    //////////////////////////////////////////////////////////////////////////
    // decode side
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
            insn_q  <= NOP_INSN;
        end else if (sys_reset_i) begin
            valid_q <= 1'b0;
            insn_q  <= NOP_INSN;
        end else if (enable_i) begin
            valid_q <= valid_next;
            if (valid_next)
                insn_q <= next_insn;
        end
    end

    // target address sits on the bus the cycle after the strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            pc_jump_q <= START_ADDRESS;
        else if (sys_reset_i)
            pc_jump_q <= START_ADDRESS;
        else if (redirect_q)
            pc_jump_q <= instruction_address_i;
    end

    // squash until the first word of the new stream is issued
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            jumping_q <= 1'b1;
        else if (sys_reset_i)
            jumping_q <= 1'b1;
        else if (redirect_taken_i)
            jumping_q <= 1'b1;
        else if (enable_i && valid_next)
            jumping_q <= 1'b0;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_q <= START_ADDRESS;
        end else if (sys_reset_i) begin
            pc_q <= START_ADDRESS;
        end else if (enable_i && valid_next) begin
            pc_q <= jumping_q ? pc_jump_q : pc_q + addr_t'(WORD_BYTES);
        end
    end

    assign issue_o = '{valid: valid_q, jumping: jumping_q, insn: insn_q, pc: pc_q};

endmodule

`default_nettype wire

// File: fetch_top.sv
/*
 * Instruction fetch stage of the core.
 * Connects the address generator, the instruction buffer and the issue
 * registers; memory answers one cycle after a non-busy address.
 */

`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
    parameter fetch_cfg_pkg::addr_t START_ADDRESS         = fetch_cfg_pkg::DEFAULT_START_ADDRESS,
    parameter int unsigned          BUFFER_DEPTH          = fetch_cfg_pkg::DEFAULT_BUFFER_DEPTH,
    parameter int unsigned          ALMOST_FULL_THRESHOLD = fetch_cfg_pkg::DEFAULT_ALMOST_FULL
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       sys_reset_i,
    input  logic                       enable_i,
    input  logic                       busy_i,
    input  fetch_types_pkg::redirect_t redirect_i,
    input  fetch_cfg_pkg::insn_t       instruction_data_i,
    output fetch_cfg_pkg::addr_t       instruction_address_o,
    output fetch_types_pkg::issue_t    issue_o
);

    import fetch_cfg_pkg::*;

    logic  redirect_taken;
    logic  push;
    logic  push_done;
    logic  buf_valid;
    logic  almost_full;
    insn_t buf_data;

    //////////////////////////////////////////////////////////////////////////
    // address generation
    //////////////////////////////////////////////////////////////////////////

    fetch_addr_gen #(
        .START_ADDRESS(START_ADDRESS)
    ) u_addr_gen (
        .clk                  (clk),
        .reset_n              (reset_n),
        .sys_reset_i          (sys_reset_i),
        .busy_i               (busy_i),
        .enable_i             (enable_i),
        .almost_full_i        (almost_full),
        .push_done_i          (push_done),
        .redirect_i           (redirect_i),
        .redirect_taken_o     (redirect_taken),
        .instruction_address_o(instruction_address_o)
    );

    // decode pops one word per enabled cycle
    fetch_ring_buffer #(
        .DATA_WIDTH           (XLEN),
        .BUFFER_DEPTH         (BUFFER_DEPTH),
        .ALMOST_FULL_THRESHOLD(ALMOST_FULL_THRESHOLD)
    ) u_ring_buffer (
        .clk             (clk),
        .reset_n         (reset_n),
        .sys_reset_i     (sys_reset_i),
        .redirect_taken_i(redirect_taken),
        .push_i          (push),
        .pop_i           (enable_i),
        .data_i          (instruction_data_i),
        .push_done_o     (push_done),
        .buf_valid_o     (buf_valid),
        .almost_full_o   (almost_full),
        .data_o          (buf_data)
    );

    //////////////////////////////////////////////////////////////////////////
    // issue toward decode
    //////////////////////////////////////////////////////////////////////////

    fetch_issue #(
        .START_ADDRESS(START_ADDRESS)
    ) u_issue (
        .clk                  (clk),
        .reset_n              (reset_n),
        .sys_reset_i          (sys_reset_i),
        .busy_i               (busy_i),
        .enable_i             (enable_i),
        .redirect_taken_i     (redirect_taken),
        .buf_valid_i          (buf_valid),
        .buf_data_i           (buf_data),
        .instruction_data_i   (instruction_data_i),
        .instruction_address_i(instruction_address_o),
        .push_o               (push),
        .issue_o              (issue_o)
    );

endmodule

`default_nettype wire

// File: fetch_assert.sv
/*
 * Concurrent checks on the fetch stage, bound into fetch_top.
 * Covers word alignment of the fetch address, the redirect target
 * one cycle after a strobe and the issue slot after a soft reset.
 */

`timescale 1ns/100ps
`default_nettype none

module fetch_assert (
    input logic                       clk,
    input logic                       reset_n,
    input logic                       sys_reset_i,
    input fetch_types_pkg::redirect_t redirect_i,
    input fetch_cfg_pkg::addr_t       fetch_addr_i,
    input fetch_types_pkg::issue_t    issue_i
);

    import fetch_cfg_pkg::*;

    logic  redirect;
    addr_t expected_target;

    assign redirect = redirect_i.jump || redirect_i.ctx_switch;

    // context switch wins when both strobes are high
    assign expected_target = redirect_i.ctx_switch ? redirect_i.ctx_target
                                                   : redirect_i.jump_target;

    a_word_aligned: assert property (
        @(posedge clk) disable iff (!reset_n)
        fetch_addr_i[1:0] == 2'b00
    ) else $error("fetch address %h is not word aligned", fetch_addr_i);

    // soft reset takes priority over a redirect
    a_redirect_target: assert property (
        @(posedge clk) disable iff (!reset_n)
        (redirect && !sys_reset_i) |=> (fetch_addr_i == $past(expected_target))
    ) else $error("fetch address %h is not the redirect target", fetch_addr_i);

    a_soft_reset_valid: assert property (
        @(posedge clk) disable iff (!reset_n)
        sys_reset_i |=> !issue_i.valid
    ) else $error("valid still high one cycle after soft reset");

endmodule

bind fetch_top fetch_assert u_fetch_assert (
    .clk         (clk),
    .reset_n     (reset_n),
    .sys_reset_i (sys_reset_i),
    .redirect_i  (redirect_i),
    .fetch_addr_i(instruction_address_o),
    .issue_i     (issue_o)
);

`default_nettype wire

// File: tb_fetch.sv
/*
 * Directed testbench of the instruction fetch stage.
 * A one-cycle memory model answers every non-busy address, a monitor
 * records each delivered instruction, and the tests check the pc order.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_fetch;

    import fetch_cfg_pkg::*;
    import fetch_types_pkg::*;

    localparam addr_t START   = 32'h0000_0100;
    localparam insn_t MEM_KEY = 32'h5a3c_96e1;
    localparam insn_t POISON  = 32'hdead_beef;
    localparam int    TIMEOUT = 2000;

    logic      clk                = 1'b0;
    logic      reset_n            = 1'b0;
    logic      sys_reset_i        = 1'b0;
    logic      enable_i           = 1'b0;
    logic      busy_i             = 1'b0;
    redirect_t redirect_i         = '0;
    insn_t     instruction_data_i = POISON;
    addr_t     instruction_address_o;
    issue_t    issue_o;

    // pcs of delivered instructions in order of delivery
    addr_t delivered[$];
    addr_t next_pc;
    int    errors;
    int    tests_run;
    int    tests_failed;

    fetch_top #(
        .START_ADDRESS        (START),
        .BUFFER_DEPTH         (DEFAULT_BUFFER_DEPTH),
        .ALMOST_FULL_THRESHOLD(DEFAULT_ALMOST_FULL)
    ) dut_i (
        .clk                  (clk),
        .reset_n              (reset_n),
        .sys_reset_i          (sys_reset_i),
        .enable_i             (enable_i),
        .busy_i               (busy_i),
        .redirect_i           (redirect_i),
        .instruction_data_i   (instruction_data_i),
        .instruction_address_o(instruction_address_o),
        .issue_o              (issue_o)
    );

    // 10 ns period
    always #5 clk = ~clk;

    // memory contents differ for every address
    function automatic insn_t mem_word(input addr_t addr);
        return addr ^ MEM_KEY;
    endfunction

    //////////////////////////////////////////////////////////////////////////
    // memory model and delivery monitor
    //////////////////////////////////////////////////////////////////////////

    // answers one cycle after a non-busy address and returns junk after a busy one
    always @(posedge clk) begin
        if (busy_i)
            instruction_data_i <= POISON;
        else
            instruction_data_i <= mem_word(instruction_address_o);
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (reset_n && enable_i && issue_o.valid && !issue_o.jumping) begin
            check_equal(issue_o.insn, mem_word(issue_o.pc), "delivered word differs from memory");
            delivered.push_back(issue_o.pc);
        end
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s, got %h expected %h", $time, msg, actual, expected);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////////

    // random enable gaps and busy cycles until n words came out
    task automatic run_until(input int n, input int stall_pct, input int busy_pct,
                             input string tag);
        int cycles;
        cycles = 0;
        while (delivered.size() < n && cycles < TIMEOUT) begin
            @(posedge clk);
            enable_i <= ($urandom % 100) >= stall_pct;
            busy_i   <= ($urandom % 100) < busy_pct;
            cycles++;
        end
        if (delivered.size() < n) begin
            $display("timeout: %s got only %0d of %0d instructions within %0d cycles",
                     tag, delivered.size(), n, TIMEOUT);
            errors++;
        end
    endtask

    // pcs must step one word at a time from next_pc
    task automatic check_stream(input int n, input string tag);
        addr_t pc;
        int    i;
        i = 0;
        while (i < n && delivered.size() > 0) begin
            pc = delivered.pop_front();
            check_equal(pc, next_pc, {tag, ": pc out of sequence"});
            next_pc = next_pc + addr_t'(WORD_BYTES);
            i++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////////

    // reset_n just released and no active edge seen yet
    task automatic test_reset_state();
        int err0;
        err0 = errors;
        @(negedge clk);
        check_equal(issue_o.valid, 1'b0, "valid after reset");
        check_equal(issue_o.jumping, 1'b1, "jumping after reset");
        check_equal(issue_o.pc, START, "pc after reset");
        check_equal(issue_o.insn, NOP_INSN, "instruction after reset");
        check_equal(instruction_address_o, START, "fetch address after reset");
        finish_test("reset state", err0);
    endtask

    task automatic test_stream(input string name, input int n, input int stall_pct,
                               input int busy_pct);
        int err0;
        err0 = errors;
        run_until(n, stall_pct, busy_pct, name);
        check_stream(n, name);
        finish_test(name, err0);
    endtask

    task automatic test_redirect(input string name, input logic jump, input logic ctx,
                                 input addr_t jump_target, input addr_t ctx_target,
                                 input addr_t first_pc, input int stall_pct);
        int err0;
        err0 = errors;
        @(posedge clk);
        enable_i   <= 1'b1;
        busy_i     <= 1'b0;
        redirect_i <= '{jump: jump, ctx_switch: ctx,
                        jump_target: jump_target, ctx_target: ctx_target};
        @(posedge clk);
        redirect_i <= '0;
        // anything recorded so far is the old stream
        delivered.delete();
        next_pc = first_pc;
        run_until(12, stall_pct, 0, name);
        check_stream(12, name);
        finish_test(name, err0);
    endtask

    task automatic test_soft_reset();
        int err0;
        err0 = errors;
        run_until(6, 30, 30, "soft reset");
        check_stream(6, "soft reset");
        @(posedge clk);
        sys_reset_i <= 1'b1;
        @(posedge clk);
        sys_reset_i <= 1'b0;
        delivered.delete();
        next_pc = START;
        run_until(16, 30, 30, "soft reset");
        check_stream(16, "soft reset");
        finish_test("soft reset", err0);
    endtask

    initial begin
        void'($urandom(24));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        next_pc      = START;

        repeat (10) @(posedge clk);
        reset_n <= 1'b1;

        test_reset_state();
        test_stream("sequential", 16, 0, 0);
        test_stream("decode stalls", 24, 40, 0);
        test_stream("memory busy", 24, 0, 40);
        test_redirect("jump", 1'b1, 1'b0, 32'h0000_4000, 32'h0000_0000,
                      32'h0000_4000, 0);
        test_redirect("context switch", 1'b0, 1'b1, 32'h0000_0000, 32'h0000_8000,
                      32'h0000_8000, 0);
        // context target wins over the jump target
        test_redirect("jump and context switch", 1'b1, 1'b1, 32'h0000_c000,
                      32'h0001_0000, 32'h0001_0000, 30);
        test_soft_reset();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
fetch_cfg_pkg.sv
fetch_types_pkg.sv
fetch_ring_buffer.sv
fetch_addr_gen.sv
fetch_issue.sv
fetch_top.sv
fetch_assert.sv
tb_fetch.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_fetch

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch -f build.f
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
    echo "run_sim: PASS"
    exit 0
fi

echo "run_sim: FAIL"
exit 1
